/* build.f */
lc3b_types.sv
mem_port_if.sv
arbiter.sv
fetch.sv
regfile.sv
decode.sv
execute.sv
mem.sv
write_back.sv
mp3.sv
tb_mp3.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_mp3 -f build.f -o tb_mp3_sim > sim.log 2>&1 &&
./obj_dir/tb_mp3_sim >> sim.log 2>&1 &&
grep -q "Simulation finished: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* tb_mp3.sv */
`timescale 1ns/1ps

module tb_mp3;
	import lc3b_types::*;

	localparam lc3b_word start_pc = 16'h0040;
	localparam lc3b_word data_base = 16'h0400;
	localparam lc3b_word marker_addr = 16'h043e;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic pmem_resp = 1'b0;
	lc3b_word pmem_rdata = '0;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_word pmem_wdata;

	lc3b_word image [1024];
	lc3b_word mem [1024];
	lc3b_word mm [1024];
	lc3b_word prog [$];
	lc3b_word store_addr [$];
	lc3b_word store_data [$];
	lc3b_word exp_addr [$];
	lc3b_word exp_data [$];
	// 0 draws each request latency from 1..4
	int latency;
	int wait_left;
	logic busy;
	logic marker_seen;
	int errors;

	mp3 #(.reset_pc(start_pc)) uut (
		.clk,
		.reset,
		.pmem_resp,
		.pmem_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata
	);

	always #2 clk = ~clk;

	// word memory that serves one request at a time
	always @(posedge clk) begin
		if (reset) begin
			pmem_resp <= 1'b0;
			busy = 1'b0;
			marker_seen = 1'b0;
			mem = image;
			store_addr.delete();
			store_data.delete();
		end else if (pmem_resp) begin
			pmem_resp <= 1'b0;
		end else if (busy) begin
			if (wait_left > 1) begin
				wait_left = wait_left - 1;
			end else begin
				busy = 1'b0;
				pmem_resp <= 1'b1;
				if (pmem_write) begin
					mem[pmem_address[10:1]] = pmem_wdata;
					store_addr.push_back(pmem_address);
					store_data.push_back(pmem_wdata);
					if (pmem_address == marker_addr)
						marker_seen = 1'b1;
				end else begin
					pmem_rdata <= mem[pmem_address[10:1]];
				end
			end
		end else if (pmem_read || pmem_write) begin
			busy = 1'b1;
			wait_left = (latency > 0) ? latency : int'($urandom % 4) + 1;
		end
	end

	function automatic lc3b_word add_rr(input int dr, input int sa, input int sb);
		return {4'b0001, 3'(dr), 3'(sa), 3'b000, 3'(sb)};
	endfunction

	function automatic lc3b_word add_ri(input int dr, input int sa, input int imm);
		return {4'b0001, 3'(dr), 3'(sa), 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_word and_rr(input int dr, input int sa, input int sb);
		return {4'b0101, 3'(dr), 3'(sa), 3'b000, 3'(sb)};
	endfunction

	function automatic lc3b_word and_ri(input int dr, input int sa, input int imm);
		return {4'b0101, 3'(dr), 3'(sa), 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_word not_r(input int dr, input int sa);
		return {4'b1001, 3'(dr), 3'(sa), 6'h3f};
	endfunction

	function automatic lc3b_word ldr(input int dr, input int base, input int off);
		return {4'b0110, 3'(dr), 3'(base), 6'(off)};
	endfunction

	function automatic lc3b_word str(input int sr, input int base, input int off);
		return {4'b0111, 3'(sr), 3'(base), 6'(off)};
	endfunction

	function automatic lc3b_word br(input int nzp, input int off);
		return {4'b0000, 3'(nzp), 9'(off)};
	endfunction

	task automatic check_word(input string name, input lc3b_word expected, input lc3b_word actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			errors++;
			$display("mismatch %s expected %0h got %0h", name, expected, actual);
		end
	endtask

	// no-op fill with constants in the low words and the program at start_pc
	task automatic fill_image();
		for (int i = 0; i < 1024; i++)
			image[10'(i)] = 16'hf000 | 16'(i);
		image[0] = data_base;
		image[1] = 16'h1234;
		image[2] = 16'hff0f;
		image[3] = 16'h8001;
		for (int i = 0; i < prog.size(); i++)
			image[10'(i) + start_pc[10:1]] = prog[i];
	endtask

	// every program first loads the data base into r7
	task automatic begin_program();
		prog.delete();
		prog.push_back(ldr(7, 0, 0));
	endtask

	task automatic run_program(input int lat);
		int t;
		latency = lat;
		fill_image();
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		if (pmem_read || pmem_write) begin
			errors++;
			$display("memory request while reset is high");
		end
		@(posedge clk);
		reset <= 1'b0;
		t = 0;
		@(negedge clk);
		while (!pmem_read && t < 50) begin
			@(negedge clk);
			t++;
		end
		if (pmem_read) begin
			check_word("pmem_address", start_pc, pmem_address);
		end else begin
			errors++;
			$display("no instruction read after reset was released");
		end
		t = 0;
		while (!marker_seen && t < 5000) begin
			@(negedge clk);
			t++;
		end
		if (!marker_seen) begin
			errors++;
			$display("timeout waiting for the final store");
		end
	endtask

	// ISA-level reference stepping one instruction at a time
	task automatic run_model();
		lc3b_word r [8];
		lc3b_word pc;
		lc3b_word ir;
		lc3b_word b;
		lc3b_word v;
		lc3b_word addr;
		lc3b_opcode op;
		lc3b_nzp cc;
		logic done;
		int n;
		exp_addr.delete();
		exp_data.delete();
		mm = image;
		r = '{default: '0};
		pc = start_pc;
		cc = 3'b010;
		done = 1'b0;
		n = 0;
		while (!done && n < 2000) begin
			ir = mm[pc[10:1]];
			op = lc3b_opcode'(ir[15:12]);
			pc = pc + 16'd2;
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
			case (op)
				op_add: v = r[ir[8:6]] + b;
				op_and: v = r[ir[8:6]] & b;
				op_not: v = ~r[ir[8:6]];
				op_ldr: v = mm[addr[10:1]];
				default: v = '0;
			endcase
			case (op)
				op_add, op_and, op_not, op_ldr: begin
					r[ir[11:9]] = v;
					cc = v[15] ? 3'b100 : ((v == '0) ? 3'b010 : 3'b001);
				end
				op_str: begin
					mm[addr[10:1]] = r[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(r[ir[11:9]]);
					done = (addr == marker_addr);
				end
				op_br: begin
					if ((cc & ir[11:9]) != 3'b000)
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
				end
				default: ;
			endcase
			n++;
		end
	endtask

	task automatic compare_stores();
		check_count("store count", exp_addr.size(), store_addr.size());
		for (int i = 0; i < exp_addr.size() && i < store_addr.size(); i++) begin
			check_word("pmem_address", exp_addr[i], store_addr[i]);
			check_word("pmem_wdata", exp_data[i], store_data[i]);
		end
	endtask

	task automatic compare_with_model();
		run_model();
		compare_stores();
	endtask

	task automatic reset_and_first_fetch();
		begin_program();
		prog.push_back(add_ri(1, 0, -1));
		prog.push_back(str(1, 7, 31));
		run_program(0);
		compare_with_model();
	endtask

	task automatic alu_results();
		begin_program();
		prog.push_back(ldr(1, 0, 1));
		prog.push_back(ldr(2, 0, 2));
		prog.push_back(add_rr(3, 1, 2));
		prog.push_back(str(3, 7, 0));
		prog.push_back(add_ri(4, 1, -7));
		prog.push_back(str(4, 7, 1));
		prog.push_back(and_rr(5, 1, 2));
		prog.push_back(str(5, 7, 2));
		prog.push_back(and_ri(6, 2, -3));
		prog.push_back(str(6, 7, 3));
		prog.push_back(not_r(3, 1));
		prog.push_back(str(3, 7, 4));
		// 8001 minus 2 wraps to 7fff
		prog.push_back(ldr(4, 0, 3));
		prog.push_back(add_ri(4, 4, -2));
		prog.push_back(str(4, 7, 31));
		run_program(0);
		compare_with_model();
	endtask

	task automatic dependency_chains();
		begin_program();
		prog.push_back(add_ri(1, 0, 5));
		prog.push_back(add_ri(2, 1, 3));
		prog.push_back(add_rr(3, 2, 1));
		prog.push_back(str(3, 7, 0));
		prog.push_back(and_ri(3, 3, -2));
		prog.push_back(not_r(4, 3));
		prog.push_back(add_rr(4, 4, 3));
		prog.push_back(str(4, 7, 1));
		prog.push_back(add_ri(5, 4, 1));
		prog.push_back(str(5, 7, 31));
		run_program(3);
		compare_with_model();
	endtask

	task automatic build_memory_program();
		begin_program();
		prog.push_back(add_ri(1, 0, 9));
		prog.push_back(add_rr(1, 1, 1));
		prog.push_back(str(1, 7, 5));
		prog.push_back(ldr(2, 7, 5));
		prog.push_back(add_ri(3, 2, -4));
		prog.push_back(str(3, 7, 6));
		prog.push_back(ldr(4, 0, 1));
		prog.push_back(add_rr(5, 4, 2));
		prog.push_back(str(5, 7, 31));
	endtask

	task automatic load_store_roundtrip();
		build_memory_program();
		run_program(1);
		compare_with_model();
	endtask

	task automatic branch_paths();
		begin_program();
		prog.push_back(add_ri(1, 0, 3));
		prog.push_back(br(1, 1));
		prog.push_back(str(1, 7, 1));
		prog.push_back(br(6, 1));
		prog.push_back(str(1, 7, 2));
		prog.push_back(and_ri(2, 0, 0));
		prog.push_back(br(2, 1));
		prog.push_back(str(2, 7, 3));
		prog.push_back(br(5, 1));
		prog.push_back(str(2, 7, 4));
		prog.push_back(not_r(3, 0));
		prog.push_back(br(4, 1));
		prog.push_back(str(3, 7, 5));
		prog.push_back(br(3, 1));
		prog.push_back(str(3, 7, 6));
		prog.push_back(br(7, 1));
		prog.push_back(str(3, 7, 7));
		// count down from 3 with one store per pass
		prog.push_back(add_ri(4, 0, 3));
		prog.push_back(add_ri(4, 4, -1));
		prog.push_back(str(4, 7, 8));
		prog.push_back(br(1, -3));
		prog.push_back(str(4, 7, 31));
		run_program(0);
		compare_with_model();
		// odd word slots below 0410 are the skipped stores
		foreach (store_addr[i]) begin
			if (store_addr[i][1] && store_addr[i] < 16'h0410) begin
				errors++;
				$display("store on a skipped path to address %h", store_addr[i]);
			end
		end
	endtask

	// both runs must give the model's store sequence
	task automatic latency_independence();
		build_memory_program();
		run_program(4);
		compare_with_model();
		run_program(0);
		compare_with_model();
	endtask

	initial begin
		errors = 0;
		latency = 1;
		void'($urandom(4));
		reset_and_first_fetch();
		alu_results();
		dependency_chains();
		load_store_roundtrip();
		branch_paths();
		latency_independence();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule : tb_mp3

/* mp3.sv */
`timescale 1ns/1ps

module mp3 #(
	parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic reset,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);
	import lc3b_types::*;

	logic load_regs;
	logic inst_wait;
	logic data_wait;
	logic stall;
	logic br_taken;
	lc3b_word br_target;

	// fetch/decode
	lc3b_word f_de_npc;
	lc3b_word f_de_ir;
	logic f_de_valid;

	// decode/execute
	lc3b_word de_ex_npc;
	lc3b_control_word de_ex_cw;
	lc3b_word de_ex_ir;
	lc3b_word de_ex_sr1;
	lc3b_word de_ex_sr2;
	lc3b_nzp de_ex_cc;
	lc3b_reg de_ex_dr;
	logic de_ex_valid;

	// execute/memory
	lc3b_word ex_mem_address;
	lc3b_control_word ex_mem_cw;
	lc3b_word ex_mem_result;
	lc3b_reg ex_mem_dr;
	logic ex_mem_valid;

	// memory/write-back
	lc3b_word mem_wb_data;
	lc3b_control_word mem_wb_cw;
	lc3b_word mem_wb_result;
	lc3b_reg mem_wb_dr;
	logic mem_wb_valid;

	logic wb_load_reg;
	logic wb_load_cc;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_nzp wb_cc;

	mem_port_if inst_port ();
	mem_port_if data_port ();

	// whole pipe waits on either memory side
	assign inst_wait = (inst_port.read || inst_port.write) && !inst_port.resp;
	assign data_wait = (data_port.read || data_port.write) && !data_port.resp;
	assign load_regs = !inst_wait && !data_wait;

	arbiter arbiter_int (
		.clk,
		.reset,
		.inst(inst_port),
		.data(data_port),
		.pmem_resp,
		.pmem_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata
	);

	fetch #(.reset_pc(reset_pc)) fetch_int (
		.clk,
		.reset,
		.load_regs,
		.stall,
		.br_taken,
		.br_target,
		.port(inst_port),
		.npc(f_de_npc),
		.ir(f_de_ir),
		.valid(f_de_valid)
	);

	decode decode_int (
		.clk,
		.reset,
		.load_regs,
		.npc_in(f_de_npc),
		.ir_in(f_de_ir),
		.valid_in(f_de_valid),
		.flush(br_taken),
		.wb_load_reg,
		.wb_load_cc,
		.wb_dest,
		.wb_data,
		.wb_cc,
		.ex_dest(de_ex_dr),
		.ex_load_reg(de_ex_valid && de_ex_cw.load_reg),
		.ex_load_cc(de_ex_valid && de_ex_cw.load_cc),
		.mem_dest(ex_mem_dr),
		.mem_load_reg(ex_mem_valid && ex_mem_cw.load_reg),
		.mem_load_cc(ex_mem_valid && ex_mem_cw.load_cc),
		.npc(de_ex_npc),
		.cw(de_ex_cw),
		.ir(de_ex_ir),
		.sr1(de_ex_sr1),
		.sr2(de_ex_sr2),
		.cc(de_ex_cc),
		.dr(de_ex_dr),
		.valid(de_ex_valid),
		.stall
	);

	execute execute_int (
		.clk,
		.reset,
		.load_regs,
		.npc_in(de_ex_npc),
		.cw_in(de_ex_cw),
		.ir_in(de_ex_ir),
		.sr1(de_ex_sr1),
		.sr2(de_ex_sr2),
		.cc_in(de_ex_cc),
		.dr_in(de_ex_dr),
		.valid_in(de_ex_valid),
		.address(ex_mem_address),
		.cw(ex_mem_cw),
		.result(ex_mem_result),
		.dr(ex_mem_dr),
		.valid(ex_mem_valid),
		.br_taken,
		.br_target
	);

	mem mem_int (
		.clk,
		.reset,
		.load_regs,
		.address_in(ex_mem_address),
		.cw_in(ex_mem_cw),
		.result_in(ex_mem_result),
		.dr_in(ex_mem_dr),
		.valid_in(ex_mem_valid),
		.port(data_port),
		.data(mem_wb_data),
		.cw(mem_wb_cw),
		.result(mem_wb_result),
		.dr(mem_wb_dr),
		.valid(mem_wb_valid)
	);

	write_back write_back_int (
		.cw(mem_wb_cw),
		.data(mem_wb_data),
		.result(mem_wb_result),
		.dr(mem_wb_dr),
		.valid(mem_wb_valid),
		.load_reg(wb_load_reg),
		.load_cc(wb_load_cc),
		.dest(wb_dest),
		.reg_data(wb_data),
		.cc_data(wb_cc)
	);

endmodule : mp3

/* write_back.sv */
`timescale 1ns/1ps

module write_back (
	input lc3b_types::lc3b_control_word cw,
	input lc3b_types::lc3b_word data,
	input lc3b_types::lc3b_word result,
	input lc3b_types::lc3b_reg dr,
	input logic valid,
	output logic load_reg,
	output logic load_cc,
	output lc3b_types::lc3b_reg dest,
	output lc3b_types::lc3b_word reg_data,
	output lc3b_types::lc3b_nzp cc_data
);
	import lc3b_types::*;

	assign reg_data = cw.mem_read ? data : result;

	// n, z, p from the written value
	always_comb begin
		if (reg_data[15])
			cc_data = 3'b100;
		else if (reg_data == '0)
			cc_data = 3'b010;
		else
			cc_data = 3'b001;
	end

	assign load_reg = valid && cw.load_reg;
	assign load_cc = valid && cw.load_cc;
	assign dest = dr;

endmodule : write_back

/* mem.sv */
`timescale 1ns/1ps

module mem (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input lc3b_types::lc3b_word address_in,
	input lc3b_types::lc3b_control_word cw_in,
	input lc3b_types::lc3b_word result_in,
	input lc3b_types::lc3b_reg dr_in,
	input logic valid_in,
	mem_port_if.requester port,
	output lc3b_types::lc3b_word data,
	output lc3b_types::lc3b_control_word cw,
	output lc3b_types::lc3b_word result,
	output lc3b_types::lc3b_reg dr,
	output logic valid
);
	import lc3b_types::*;

	logic done;
	lc3b_word rdata_hold;

	assign port.address = address_in;
	assign port.wdata = result_in;
	assign port.read = valid_in && cw_in.mem_read && !done;
	assign port.write = valid_in && cw_in.mem_write && !done;

	// access finished but the pipe has not moved yet
	always_ff @(posedge clk) begin
		if (reset)
			done <= 1'b0;
		else if (load_regs)
			done <= 1'b0;
		else if (port.resp)
			done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (port.resp)
			rdata_hold <= port.rdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (load_regs) begin
			valid <= valid_in;
			data <= port.resp ? port.rdata : rdata_hold;
			cw <= cw_in;
			result <= result_in;
			dr <= dr_in;
		end
	end

endmodule : mem

/* execute.sv */
`timescale 1ns/1ps

module execute (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input lc3b_types::lc3b_word npc_in,
	input lc3b_types::lc3b_control_word cw_in,
	input lc3b_types::lc3b_word ir_in,
	input lc3b_types::lc3b_word sr1,
	input lc3b_types::lc3b_word sr2,
	input lc3b_types::lc3b_nzp cc_in,
	input lc3b_types::lc3b_reg dr_in,
	input logic valid_in,
	output lc3b_types::lc3b_word address,
	output lc3b_types::lc3b_control_word cw,
	output lc3b_types::lc3b_word result,
	output lc3b_types::lc3b_reg dr,
	output logic valid,
	output logic br_taken,
	output lc3b_types::lc3b_word br_target
);
	import lc3b_types::*;

	lc3b_word imm5;
	lc3b_word off6;
	lc3b_word off9;
	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word addr;

	assign imm5 = {{11{ir_in[4]}}, ir_in[4:0]};
	// word offsets
	assign off6 = {{9{ir_in[5]}}, ir_in[5:0], 1'b0};
	assign off9 = {{6{ir_in[8]}}, ir_in[8:0], 1'b0};

	assign alu_b = cw_in.imm_sel ? imm5 : sr2;

	always_comb begin
		case (cw_in.alu_op)
			alu_add: alu_out = sr1 + alu_b;
			alu_and: alu_out = sr1 & alu_b;
			alu_not: alu_out = ~sr1;
			alu_pass: alu_out = alu_b;
			default: alu_out = alu_b;
		endcase
	end

	always_comb begin
		case (cw_in.opcode)
			op_ldr, op_str: addr = sr1 + off6;
			default: addr = npc_in + off9;
		endcase
	end

	assign br_taken = valid_in && cw_in.is_br && |(cc_in & ir_in[11:9]);
	assign br_target = addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (load_regs) begin
			valid <= valid_in;
			address <= addr;
			cw <= cw_in;
			// store data rides along here too
			result <= alu_out;
			dr <= dr_in;
		end
	end

endmodule : execute

/* decode.sv */
`timescale 1ns/1ps

module decode (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input lc3b_types::lc3b_word npc_in,
	input lc3b_types::lc3b_word ir_in,
	input logic valid_in,
	input logic flush,
	input logic wb_load_reg,
	input logic wb_load_cc,
	input lc3b_types::lc3b_reg wb_dest,
	input lc3b_types::lc3b_word wb_data,
	input lc3b_types::lc3b_nzp wb_cc,
	input lc3b_types::lc3b_reg ex_dest,
	input logic ex_load_reg,
	input logic ex_load_cc,
	input lc3b_types::lc3b_reg mem_dest,
	input logic mem_load_reg,
	input logic mem_load_cc,
	output lc3b_types::lc3b_word npc,
	output lc3b_types::lc3b_control_word cw,
	output lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_word sr1,
	output lc3b_types::lc3b_word sr2,
	output lc3b_types::lc3b_nzp cc,
	output lc3b_types::lc3b_reg dr,
	output logic valid,
	output logic stall
);
	import lc3b_types::*;

	lc3b_opcode opcode;
	lc3b_control_word ctrl;
	lc3b_reg src_a;
	lc3b_reg src_b;
	lc3b_word reg_a;
	lc3b_word reg_b;
	lc3b_nzp cc_reg;
	logic use_a;
	logic use_b;
	logic use_cc;
	logic hit_a;
	logic hit_b;
	logic hit_cc;

	regfile regfile_int (
		.clk,
		.reset,
		.load(wb_load_reg),
		.dest(wb_dest),
		.in(wb_data),
		.src_a,
		.src_b,
		.reg_a,
		.reg_b
	);

	assign opcode = lc3b_opcode'(ir_in[15:12]);
	assign src_a = ir_in[8:6];
	// str reads its data register through port b
	assign src_b = (opcode == op_str) ? ir_in[11:9] : ir_in[2:0];

	always_comb begin
		ctrl = '0;
		ctrl.opcode = opcode;
		ctrl.alu_op = alu_pass;
		use_a = 1'b0;
		use_b = 1'b0;
		use_cc = 1'b0;
		case (opcode)
			op_add, op_and: begin
				ctrl.alu_op = (opcode == op_add) ? alu_add : alu_and;
				ctrl.imm_sel = ir_in[5];
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				use_a = 1'b1;
				use_b = ~ir_in[5];
			end
			op_not: begin
				ctrl.alu_op = alu_not;
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				use_a = 1'b1;
			end
			op_ldr: begin
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.mem_read = 1'b1;
				use_a = 1'b1;
			end
			op_str: begin
				ctrl.mem_write = 1'b1;
				use_a = 1'b1;
				use_b = 1'b1;
			end
			op_br: begin
				ctrl.is_br = 1'b1;
				use_cc = 1'b1;
			end
			// anything else passes through as a no-op
			default: ;
		endcase
	end

	// pending writers further down the pipe
	assign hit_a = (ex_load_reg && src_a == ex_dest) || (mem_load_reg && src_a == mem_dest) ||
		(wb_load_reg && src_a == wb_dest);
	assign hit_b = (ex_load_reg && src_b == ex_dest) || (mem_load_reg && src_b == mem_dest) ||
		(wb_load_reg && src_b == wb_dest);
	assign hit_cc = ex_load_cc || mem_load_cc || wb_load_cc;

	assign stall = valid_in && ((use_a && hit_a) || (use_b && hit_b) || (use_cc && hit_cc));

	// registers come out of reset at zero, so z
	always_ff @(posedge clk) begin
		if (reset)
			cc_reg <= 3'b010;
		else if (wb_load_cc)
			cc_reg <= wb_cc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (load_regs) begin
			valid <= valid_in && !stall && !flush;
			npc <= npc_in;
			cw <= ctrl;
			ir <= ir_in;
			sr1 <= reg_a;
			sr2 <= reg_b;
			cc <= cc_reg;
			dr <= ir_in[11:9];
		end
	end

endmodule : decode

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word data [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				data[i] <= '0;
		end else if (load) begin
			data[dest] <= in;
		end
	end

	assign reg_a = data[src_a];
	assign reg_b = data[src_b];

endmodule : regfile

/* fetch.sv */
`timescale 1ns/1ps

module fetch #(
	parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input logic stall,
	input logic br_taken,
	input lc3b_types::lc3b_word br_target,
	mem_port_if.requester port,
	output lc3b_types::lc3b_word npc,
	output lc3b_types::lc3b_word ir,
	output logic valid
);
	import lc3b_types::*;

	lc3b_word pc;
	lc3b_word hold_ir;
	logic hold_valid;
	lc3b_word word;

	// keep reading until a word is parked
	assign port.address = pc;
	assign port.read = ~hold_valid;
	assign port.write = 1'b0;
	assign port.wdata = '0;

	assign word = hold_valid ? hold_ir : port.rdata;

	// with load_regs high the word is either parked or arriving now
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			valid <= 1'b0;
			hold_valid <= 1'b0;
		end else if (load_regs && br_taken) begin
			pc <= br_target;
			valid <= 1'b0;
			hold_valid <= 1'b0;
		end else if (load_regs && !stall) begin
			pc <= pc + 16'd2;
			npc <= pc + 16'd2;
			ir <= word;
			valid <= 1'b1;
			hold_valid <= 1'b0;
		end else if (port.resp) begin
			hold_ir <= port.rdata;
			hold_valid <= 1'b1;
		end
	end

endmodule : fetch

/* arbiter.sv */
`timescale 1ns/1ps

module arbiter (
	input logic clk,
	input logic reset,
	mem_port_if.responder inst,
	mem_port_if.responder data,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);
	import lc3b_types::*;

	arb_state state;
	arb_state next_state;

	// data side wins when both are pending
	always_comb begin
		next_state = state;
		case (state)
			arb_idle: begin
				if (data.read || data.write)
					next_state = arb_data;
				else if (inst.read)
					next_state = arb_inst;
			end
			arb_inst, arb_data: begin
				if (pmem_resp)
					next_state = arb_idle;
			end
			default: next_state = arb_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= arb_idle;
		else
			state <= next_state;
	end

	assign pmem_read = ((state == arb_inst) && inst.read) || ((state == arb_data) && data.read);
	assign pmem_write = (state == arb_data) && data.write;
	assign pmem_address = (state == arb_data) ? data.address : inst.address;
	assign pmem_wdata = data.wdata;

	// response only reaches the granted side
	assign inst.resp = (state == arb_inst) && pmem_resp;
	assign data.resp = (state == arb_data) && pmem_resp;
	assign inst.rdata = pmem_rdata;
	assign data.rdata = pmem_rdata;

endmodule : arbiter

/* mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if;
	import lc3b_types::*;

	lc3b_word address;
	logic read;
	logic write;
	lc3b_word wdata;
	lc3b_word rdata;
	logic resp;

	modport requester (
		output address, read, write, wdata,
		input rdata, resp
	);

	modport responder (
		input address, read, write, wdata,
		output rdata, resp
	);
endinterface : mem_port_if

/* lc3b_types.sv */
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// ir[15:12]
typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_alu_op;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_alu_op alu_op;
	logic imm_sel;
	logic load_reg;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic is_br;
} lc3b_control_word;

typedef enum logic [1:0] {
	arb_idle,
	arb_inst,
	arb_data
} arb_state;

endpackage : lc3b_types
